//--- common/rv_pkg.sv
package rv_pkg;

    // ========================================================================
    // data widths
    // ========================================================================
    typedef logic [31:0] word_t;        // register value, pc, immediate, operand
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [20:0] alu_op_t;      // {btype, blt, beq, calc[17:0]}
    typedef logic [2:0]  imm_type_t;
    typedef logic [3:0]  dmem_type_t;
    typedef logic [3:0]  wb_src_t;      // one-hot

    // ========================================================================
    // opcodes
    // ========================================================================
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

    // alu calculation codes, one-hot
    localparam logic [17:0] ALUOP_ADD    = 18'h00001;
    localparam logic [17:0] ALUOP_SUB    = 18'h00002;
    localparam logic [17:0] ALUOP_SLL    = 18'h00004;
    localparam logic [17:0] ALUOP_SLT    = 18'h00008;
    localparam logic [17:0] ALUOP_SLTU   = 18'h00010;
    localparam logic [17:0] ALUOP_XOR    = 18'h00020;
    localparam logic [17:0] ALUOP_SRL    = 18'h00040;
    localparam logic [17:0] ALUOP_SRA    = 18'h00080;
    localparam logic [17:0] ALUOP_OR     = 18'h00100;
    localparam logic [17:0] ALUOP_AND    = 18'h00200;
    localparam logic [17:0] ALUOP_MUL    = 18'h00400;  // m extension from here
    localparam logic [17:0] ALUOP_MULH   = 18'h00800;
    localparam logic [17:0] ALUOP_MULHSU = 18'h01000;
    localparam logic [17:0] ALUOP_MULHU  = 18'h02000;
    localparam logic [17:0] ALUOP_DIV    = 18'h04000;
    localparam logic [17:0] ALUOP_DIVU   = 18'h08000;
    localparam logic [17:0] ALUOP_REM    = 18'h10000;
    localparam logic [17:0] ALUOP_REMU   = 18'h20000;

    // immediate formats
    localparam imm_type_t IMM_NO = 3'd0;
    localparam imm_type_t IMM_I  = 3'd1;
    localparam imm_type_t IMM_S  = 3'd2;
    localparam imm_type_t IMM_B  = 3'd3;
    localparam imm_type_t IMM_U  = 3'd4;
    localparam imm_type_t IMM_J  = 3'd5;

    // data memory access
    localparam dmem_type_t DMEM_NONE = 4'd0;
    localparam dmem_type_t DMEM_LB   = 4'd1;
    localparam dmem_type_t DMEM_LH   = 4'd2;
    localparam dmem_type_t DMEM_LW   = 4'd3;
    localparam dmem_type_t DMEM_LBU  = 4'd4;
    localparam dmem_type_t DMEM_LHU  = 4'd5;
    localparam dmem_type_t DMEM_SB   = 4'd6;
    localparam dmem_type_t DMEM_SH   = 4'd7;
    localparam dmem_type_t DMEM_SW   = 4'd8;

    localparam wb_src_t WBSRC_ALU = 4'b0001;
    localparam wb_src_t WBSRC_MEM = 4'b0010;
    localparam wb_src_t WBSRC_PC  = 4'b0100;   // link address for jumps
    localparam wb_src_t WBSRC_IMM = 4'b1000;   // lui

    localparam logic RS1SEL_RF  = 1'b0;
    localparam logic RS1SEL_PC  = 1'b1;
    localparam logic RS2SEL_RF  = 1'b0;
    localparam logic RS2SEL_IMM = 1'b1;

    localparam instr_t INSTR_NOP = 32'h00000013;   // addi x0, x0, 0

    typedef enum logic {ID_IDLE, ID_ACK} id_state_t;

endpackage

//--- hw/id_stage/decoder.sv
module decoder import rv_pkg::*; (
    input  instr_t     instruction_i,
    output alu_op_t    alu_op_o,
    output logic       rs1_sel_o,        // 0 rs1 data, 1 pc
    output logic       rs2_sel_o,        // 0 rs2 data, 1 immediate
    output imm_type_t  imm_type_o,
    output logic       branch_btype_o,
    output logic       branch_jal_o,
    output logic       branch_jalr_o,
    output dmem_type_t dmem_type_o,
    output wb_src_t    wb_src_o,
    output logic       wb_en_o,
    output logic       instr_illegal_o
);

    // ========================================================================
    // instruction fields
    // ========================================================================
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7_b5;              // bit 30, sub/sra select
    logic        mext;                   // bit 25, m extension in r-type
    logic [17:0] alu_calc;
    logic        beq;
    logic        blt;

    assign opcode    = instruction_i[6:0];
    assign funct3    = instruction_i[14:12];
    assign funct7_b5 = instruction_i[30];
    assign mext      = instruction_i[25];

    assign alu_op_o = {branch_btype_o, blt, beq, alu_calc};

    // ========================================================================
    // main decode
    // ========================================================================
    always_comb begin
        alu_calc        = ALUOP_ADD;
        rs1_sel_o       = RS1SEL_RF;
        rs2_sel_o       = RS2SEL_IMM;
        imm_type_o      = IMM_NO;
        beq             = 1'b0;
        blt             = 1'b0;
        branch_btype_o  = 1'b0;
        branch_jal_o    = 1'b0;
        branch_jalr_o   = 1'b0;
        dmem_type_o     = DMEM_NONE;
        wb_src_o        = WBSRC_ALU;
        wb_en_o         = 1'b0;
        instr_illegal_o = 1'b0;
        case (opcode)
            OPCODE_LOAD: begin
                imm_type_o = IMM_I;
                wb_src_o   = WBSRC_MEM;
                wb_en_o    = 1'b1;
                case (funct3)
                    3'b000:  dmem_type_o = DMEM_LB;
                    3'b001:  dmem_type_o = DMEM_LH;
                    3'b010:  dmem_type_o = DMEM_LW;
                    3'b100:  dmem_type_o = DMEM_LBU;
                    3'b101:  dmem_type_o = DMEM_LHU;
                    default: instr_illegal_o = 1'b1;
                endcase
            end
            OPCODE_OP_IMM: begin
                imm_type_o = IMM_I;
                wb_en_o    = (instruction_i != INSTR_NOP);   // nop writes nothing
                case (funct3)
                    3'b000: alu_calc = ALUOP_ADD;
                    3'b001: alu_calc = ALUOP_SLL;
                    3'b010: alu_calc = ALUOP_SLT;
                    3'b011: alu_calc = ALUOP_SLTU;
                    3'b100: alu_calc = ALUOP_XOR;
                    3'b101: alu_calc = funct7_b5 ? ALUOP_SRA : ALUOP_SRL;
                    3'b110: alu_calc = ALUOP_OR;
                    3'b111: alu_calc = ALUOP_AND;
                endcase
            end
            OPCODE_AUIPC: begin
                imm_type_o = IMM_U;
                rs1_sel_o  = RS1SEL_PC;
                wb_en_o    = 1'b1;
            end
            OPCODE_STORE: begin
                imm_type_o = IMM_S;
                rs2_sel_o  = RS2SEL_RF;          // rs2 carries store data path
                case (funct3)
                    3'b000:  dmem_type_o = DMEM_SB;
                    3'b001:  dmem_type_o = DMEM_SH;
                    3'b010:  dmem_type_o = DMEM_SW;
                    default: instr_illegal_o = 1'b1;
                endcase
            end
            OPCODE_RTYPE: begin
                rs2_sel_o = RS2SEL_RF;
                wb_en_o   = 1'b1;
                if (!mext) begin
                    case (funct3)
                        3'b000: alu_calc = funct7_b5 ? ALUOP_SUB : ALUOP_ADD;
                        3'b001: alu_calc = ALUOP_SLL;
                        3'b010: alu_calc = ALUOP_SLT;
                        3'b011: alu_calc = ALUOP_SLTU;
                        3'b100: alu_calc = ALUOP_XOR;
                        3'b101: alu_calc = funct7_b5 ? ALUOP_SRA : ALUOP_SRL;
                        3'b110: alu_calc = ALUOP_OR;
                        3'b111: alu_calc = ALUOP_AND;
                    endcase
                end else begin
                    case (funct3)
                        3'b000: alu_calc = ALUOP_MUL;
                        3'b001: alu_calc = ALUOP_MULH;
                        3'b010: alu_calc = ALUOP_MULHSU;
                        3'b011: alu_calc = ALUOP_MULHU;
                        3'b100: alu_calc = ALUOP_DIV;
                        3'b101: alu_calc = ALUOP_DIVU;
                        3'b110: alu_calc = ALUOP_REM;
                        3'b111: alu_calc = ALUOP_REMU;
                    endcase
                end
            end
            OPCODE_LUI: begin
                imm_type_o = IMM_U;
                wb_src_o   = WBSRC_IMM;
                wb_en_o    = 1'b1;
            end
            OPCODE_BRANCH: begin
                imm_type_o     = IMM_B;
                branch_btype_o = 1'b1;
                rs2_sel_o      = RS2SEL_RF;
                case (funct3)
                    3'b000: begin               // beq
                        alu_calc = ALUOP_SUB;
                        beq      = 1'b1;
                    end
                    3'b001: alu_calc = ALUOP_SUB;   // bne
                    3'b100: begin               // blt
                        alu_calc = ALUOP_SLT;
                        blt      = 1'b1;
                    end
                    3'b101: alu_calc = ALUOP_SLT;   // bge
                    3'b110: begin               // bltu
                        alu_calc = ALUOP_SLTU;
                        blt      = 1'b1;
                    end
                    3'b111: alu_calc = ALUOP_SLTU;  // bgeu
                    default: instr_illegal_o = 1'b1;
                endcase
            end
            OPCODE_JALR: begin
                imm_type_o    = IMM_I;
                branch_jalr_o = 1'b1;
                wb_src_o      = WBSRC_PC;
                wb_en_o       = 1'b1;
            end
            OPCODE_JAL: begin
                imm_type_o   = IMM_J;
                branch_jal_o = 1'b1;
                wb_src_o     = WBSRC_PC;
                wb_en_o      = 1'b1;
            end
            default: instr_illegal_o = 1'b1;   // system/csr land here too
        endcase
    end

endmodule

//--- hw/id_stage/imm_gen.sv
module imm_gen import rv_pkg::*; (
    input  instr_t    instruction_i,
    input  imm_type_t imm_type_i,
    output word_t     imm_o
);

    logic sign;

    assign sign = instruction_i[31];    // every format extends from bit 31

    always_comb begin
        case (imm_type_i)
            IMM_I: imm_o = {{20{sign}}, instruction_i[31:20]};
            IMM_S: imm_o = {{20{sign}}, instruction_i[31:25], instruction_i[11:7]};
            IMM_B: begin
                imm_o = {{19{sign}}, instruction_i[31], instruction_i[7],
                         instruction_i[30:25], instruction_i[11:8], 1'b0};
            end
            IMM_U: imm_o = {instruction_i[31:12], 12'b0};
            IMM_J: begin
                imm_o = {{11{sign}}, instruction_i[31], instruction_i[19:12],
                         instruction_i[20], instruction_i[30:21], 1'b0};
            end
            default: imm_o = '0;         // IMM_NO and unused codes
        endcase
    end

endmodule

//--- hw/id_stage/reg_file.sv
module reg_file import rv_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  logic      we_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     rd_data_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs_q [31:1];   // x0 has no storage

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0) begin
            regs_q[rd_addr_i] <= rd_data_i;
        end
    end

    // no bypass, same-cycle read sees the old value
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    // a write aimed at x0 leaves every entry unchanged
    a_x0_untouched: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (we_i && rd_addr_i == '0) |=> (!$stable(rs1_addr_i) || $stable(rs1_data_o))
    );

    a_write_then_read: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (we_i && rd_addr_i != '0) |=>
            (rs1_addr_i != $past(rd_addr_i) || rs1_data_o == $past(rd_data_i))
    );

endmodule

//--- hw/id_stage/id_stage.sv
module id_stage import rv_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    // fetch side, four-phase req/ack
    input  logic       req_i,
    input  instr_t     instr_i,
    input  word_t      pc_i,
    // write-back port
    input  logic       wb_we_i,
    input  reg_addr_t  wb_rd_i,
    input  word_t      wb_data_i,
    output logic       ack_o,
    output alu_op_t    alu_op_o,
    output word_t      op_a_o,
    output word_t      op_b_o,
    output word_t      imm_o,
    output word_t      rs2_data_o,
    output reg_addr_t  rd_o,
    output dmem_type_t dmem_type_o,
    output wb_src_t    wb_src_o,
    output logic       wb_en_o,
    output logic       branch_btype_o,
    output logic       branch_jal_o,
    output logic       branch_jalr_o,
    output logic       illegal_o
);

    // ========================================================================
    // decode and operand paths
    // ========================================================================
    alu_op_t    dec_alu_op;
    logic       dec_rs1_sel, dec_rs2_sel;
    imm_type_t  dec_imm_type;
    logic       dec_btype, dec_jal, dec_jalr;
    dmem_type_t dec_dmem_type;
    wb_src_t    dec_wb_src;
    logic       dec_wb_en, dec_illegal;
    word_t      imm, rs1_data, rs2_data;
    word_t      op_a, op_b;
    id_state_t  state_q;
    logic       capture;

    decoder u_decoder (
        .instruction_i   (instr_i),
        .alu_op_o        (dec_alu_op),
        .rs1_sel_o       (dec_rs1_sel),
        .rs2_sel_o       (dec_rs2_sel),
        .imm_type_o      (dec_imm_type),
        .branch_btype_o  (dec_btype),
        .branch_jal_o    (dec_jal),
        .branch_jalr_o   (dec_jalr),
        .dmem_type_o     (dec_dmem_type),
        .wb_src_o        (dec_wb_src),
        .wb_en_o         (dec_wb_en),
        .instr_illegal_o (dec_illegal)
    );

    imm_gen u_imm_gen (
        .instruction_i (instr_i),
        .imm_type_i    (dec_imm_type),
        .imm_o         (imm)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (instr_i[19:15]),
        .rs2_addr_i (instr_i[24:20]),
        .we_i       (wb_we_i),
        .rd_addr_i  (wb_rd_i),
        .rd_data_i  (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    assign op_a = (dec_rs1_sel == RS1SEL_PC) ? pc_i : rs1_data;   // auipc
    assign op_b = (dec_rs2_sel == RS2SEL_IMM) ? imm : rs2_data;

    // ========================================================================
    // handshake controller and output bank
    // ========================================================================
    assign capture = (state_q == ID_IDLE) && req_i;
    assign ack_o   = (state_q == ID_ACK);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ID_IDLE;
        end else begin
            case (state_q)
                ID_IDLE: if (req_i) state_q <= ID_ACK;
                ID_ACK:  if (!req_i) state_q <= ID_IDLE;   // fetch dropped req
                default: state_q <= ID_IDLE;
            endcase
        end
    end

    // control part of the bundle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dmem_type_o    <= DMEM_NONE;
            wb_en_o        <= 1'b0;
            branch_btype_o <= 1'b0;
            branch_jal_o   <= 1'b0;
            branch_jalr_o  <= 1'b0;
            illegal_o      <= 1'b0;
        end else if (capture) begin
            dmem_type_o    <= dec_dmem_type;
            wb_en_o        <= dec_wb_en;
            branch_btype_o <= dec_btype;
            branch_jal_o   <= dec_jal;
            branch_jalr_o  <= dec_jalr;
            illegal_o      <= dec_illegal;
        end
    end

    // data part of the bundle
    always_ff @(posedge clk_i) begin
        if (capture) begin
            alu_op_o   <= dec_alu_op;
            op_a_o     <= op_a;
            op_b_o     <= op_b;
            imm_o      <= imm;
            rs2_data_o <= rs2_data;
            rd_o       <= instr_i[11:7];
            wb_src_o   <= dec_wb_src;
        end
    end

    a_bundle_frozen: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ack_o |=> $stable({alu_op_o, op_a_o, op_b_o, imm_o, rs2_data_o, rd_o,
                           dmem_type_o, wb_src_o, wb_en_o, branch_btype_o,
                           branch_jal_o, branch_jalr_o, illegal_o})
    );

    a_ack_needs_req: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i)
    );

endmodule

//--- tests/tb_id_vectors.svh
`ifndef TB_ID_VECTORS_SVH
`define TB_ID_VECTORS_SVH

// columns: name, instruction, pc, alu_op, wb_src, dmem_type,
//          flags {wb_en, btype, jal, jalr, illegal}, immediate
task automatic fill_vector_table();
    // loads, rd x8, rs1 x9
    add_vec("lb",      32'h01048403, 32'h00001000, {3'b000, ALUOP_ADD},
            WBSRC_MEM, DMEM_LB,   5'b1_000_0, 32'h00000010);
    add_vec("lh",      32'hFFC49403, 32'h00001004, {3'b000, ALUOP_ADD},
            WBSRC_MEM, DMEM_LH,   5'b1_000_0, 32'hFFFFFFFC);
    add_vec("lw",      32'h1004A403, 32'h00001008, {3'b000, ALUOP_ADD},
            WBSRC_MEM, DMEM_LW,   5'b1_000_0, 32'h00000100);
    add_vec("lbu",     32'hFFF4C403, 32'h0000100C, {3'b000, ALUOP_ADD},
            WBSRC_MEM, DMEM_LBU,  5'b1_000_0, 32'hFFFFFFFF);
    add_vec("lhu",     32'h7FE4D403, 32'h00001010, {3'b000, ALUOP_ADD},
            WBSRC_MEM, DMEM_LHU,  5'b1_000_0, 32'h000007FE);
    // stores, rs1 x10, rs2 x11
    add_vec("sb",      32'h00B50A23, 32'h00001014, {3'b000, ALUOP_ADD},
            WBSRC_ALU, DMEM_SB,   5'b0_000_0, 32'h00000014);
    add_vec("sh",      32'hFEB51C23, 32'h00001018, {3'b000, ALUOP_ADD},
            WBSRC_ALU, DMEM_SH,   5'b0_000_0, 32'hFFFFFFF8);
    add_vec("sw",      32'h7EB52E23, 32'h0000101C, {3'b000, ALUOP_ADD},
            WBSRC_ALU, DMEM_SW,   5'b0_000_0, 32'h000007FC);
    // op-imm, rd x4, rs1 x6
    add_vec("addi",    32'hFFB30213, 32'h00001020, {3'b000, ALUOP_ADD},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'hFFFFFFFB);
    add_vec("slti",    32'h06432213, 32'h00001024, {3'b000, ALUOP_SLT},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000064);
    add_vec("sltiu",   32'hFFF33213, 32'h00001028, {3'b000, ALUOP_SLTU},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'hFFFFFFFF);
    add_vec("xori",    32'h7FF34213, 32'h0000102C, {3'b000, ALUOP_XOR},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h000007FF);
    add_vec("ori",     32'h80036213, 32'h00001030, {3'b000, ALUOP_OR},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'hFFFFF800);
    add_vec("andi",    32'h0F037213, 32'h00001034, {3'b000, ALUOP_AND},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h000000F0);
    add_vec("slli",    32'h00331213, 32'h00001038, {3'b000, ALUOP_SLL},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000003);
    add_vec("srli",    32'h00735213, 32'h0000103C, {3'b000, ALUOP_SRL},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000007);
    add_vec("srai",    32'h40735213, 32'h00001040, {3'b000, ALUOP_SRA},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000407);
    // r-type, rd x3, rs1 x1, rs2 x2
    add_vec("add",     32'h002081B3, 32'h00001044, {3'b000, ALUOP_ADD},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("sub",     32'h402081B3, 32'h00001048, {3'b000, ALUOP_SUB},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("sll",     32'h002091B3, 32'h0000104C, {3'b000, ALUOP_SLL},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("slt",     32'h0020A1B3, 32'h00001050, {3'b000, ALUOP_SLT},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("sltu",    32'h0020B1B3, 32'h00001054, {3'b000, ALUOP_SLTU},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("xor",     32'h0020C1B3, 32'h00001058, {3'b000, ALUOP_XOR},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("srl",     32'h0020D1B3, 32'h0000105C, {3'b000, ALUOP_SRL},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("sra",     32'h4020D1B3, 32'h00001060, {3'b000, ALUOP_SRA},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("or",      32'h0020E1B3, 32'h00001064, {3'b000, ALUOP_OR},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("and",     32'h0020F1B3, 32'h00001068, {3'b000, ALUOP_AND},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    // m extension, same registers
    add_vec("mul",     32'h022081B3, 32'h0000106C, {3'b000, ALUOP_MUL},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("mulh",    32'h022091B3, 32'h00001070, {3'b000, ALUOP_MULH},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("mulhsu",  32'h0220A1B3, 32'h00001074, {3'b000, ALUOP_MULHSU},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("mulhu",   32'h0220B1B3, 32'h00001078, {3'b000, ALUOP_MULHU},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("div",     32'h0220C1B3, 32'h0000107C, {3'b000, ALUOP_DIV},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("divu",    32'h0220D1B3, 32'h00001080, {3'b000, ALUOP_DIVU},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("rem",     32'h0220E1B3, 32'h00001084, {3'b000, ALUOP_REM},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("remu",    32'h0220F1B3, 32'h00001088, {3'b000, ALUOP_REMU},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    // branches, rs1 x12, rs2 x13
    add_vec("beq",     32'h00D60463, 32'h0000108C, {3'b101, ALUOP_SUB},
            WBSRC_ALU, DMEM_NONE, 5'b0_100_0, 32'h00000008);
    add_vec("bne",     32'hFED61CE3, 32'h00001090, {3'b100, ALUOP_SUB},
            WBSRC_ALU, DMEM_NONE, 5'b0_100_0, 32'hFFFFFFF8);
    add_vec("blt",     32'h00D640E3, 32'h00001094, {3'b110, ALUOP_SLT},
            WBSRC_ALU, DMEM_NONE, 5'b0_100_0, 32'h00000800);
    add_vec("bge",     32'h80D65063, 32'h00001098, {3'b100, ALUOP_SLT},
            WBSRC_ALU, DMEM_NONE, 5'b0_100_0, 32'hFFFFF000);
    add_vec("bltu",    32'h06D66F63, 32'h0000109C, {3'b110, ALUOP_SLTU},
            WBSRC_ALU, DMEM_NONE, 5'b0_100_0, 32'h0000007E);
    add_vec("bgeu",    32'hFED67FE3, 32'h000010A0, {3'b100, ALUOP_SLTU},
            WBSRC_ALU, DMEM_NONE, 5'b0_100_0, 32'hFFFFFFFE);
    // upper immediates and jumps
    add_vec("lui",     32'hABCDE737, 32'h000010A4, {3'b000, ALUOP_ADD},
            WBSRC_IMM, DMEM_NONE, 5'b1_000_0, 32'hABCDE000);
    add_vec("auipc",   32'h80001797, 32'h80002468, {3'b000, ALUOP_ADD},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h80001000);
    add_vec("jal_fwd", 32'h344120EF, 32'h000010AC, {3'b000, ALUOP_ADD},
            WBSRC_PC,  DMEM_NONE, 5'b1_010_0, 32'h00012344);
    add_vec("jal_back", 32'hFF1FF0EF, 32'h000010B0, {3'b000, ALUOP_ADD},
            WBSRC_PC,  DMEM_NONE, 5'b1_010_0, 32'hFFFFFFF0);
    add_vec("jalr",    32'hFF4280E7, 32'h000010B4, {3'b000, ALUOP_ADD},
            WBSRC_PC,  DMEM_NONE, 5'b1_001_0, 32'hFFFFFFF4);
    // nop, x0 source and illegal forms
    add_vec("nop",     32'h00000013, 32'h000010B8, {3'b000, ALUOP_ADD},
            WBSRC_ALU, DMEM_NONE, 5'b0_000_0, 32'h00000000);
    add_vec("add_x0",  32'h007002B3, 32'h000010BC, {3'b000, ALUOP_ADD},
            WBSRC_ALU, DMEM_NONE, 5'b1_000_0, 32'h00000000);
    add_vec("bad_opc", 32'hFFFFFFFF, 32'h000010C0, {3'b000, ALUOP_ADD},
            WBSRC_ALU, DMEM_NONE, 5'b0_000_1, 32'h00000000);
    add_vec("ecall",   32'h00000073, 32'h000010C4, {3'b000, ALUOP_ADD},
            WBSRC_ALU, DMEM_NONE, 5'b0_000_1, 32'h00000000);
    add_vec("bad_load", 32'h0004B403, 32'h000010C8, {3'b000, ALUOP_ADD},
            WBSRC_MEM, DMEM_NONE, 5'b1_000_1, 32'h00000000);
    add_vec("bad_br",  32'h00D62063, 32'h000010CC, {3'b100, ALUOP_ADD},
            WBSRC_ALU, DMEM_NONE, 5'b0_100_1, 32'h00000000);
endtask

`endif

//--- tests/tb_id_stage.sv
module tb_id_stage import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // ========================================================================
    // DUT and clock
    // ========================================================================
    logic       clk = 1'b0;
    logic       rst_n;
    logic       req;
    instr_t     instr;
    word_t      pc;
    logic       wb_we;
    reg_addr_t  wb_rd;
    word_t      wb_data;
    logic       ack;
    alu_op_t    alu_op;
    word_t      op_a;
    word_t      op_b;
    word_t      imm;
    word_t      rs2_data;
    reg_addr_t  rd;
    dmem_type_t dmem_type;
    wb_src_t    wb_src;
    logic       wb_en;
    logic       btype;
    logic       jal;
    logic       jalr;
    logic       illegal;

    always #50 clk = ~clk;              // 100 ns period

    id_stage uut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .req_i          (req),
        .instr_i        (instr),
        .pc_i           (pc),
        .wb_we_i        (wb_we),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .ack_o          (ack),
        .alu_op_o       (alu_op),
        .op_a_o         (op_a),
        .op_b_o         (op_b),
        .imm_o          (imm),
        .rs2_data_o     (rs2_data),
        .rd_o           (rd),
        .dmem_type_o    (dmem_type),
        .wb_src_o       (wb_src),
        .wb_en_o        (wb_en),
        .branch_btype_o (btype),
        .branch_jal_o   (jal),
        .branch_jalr_o  (jalr),
        .illegal_o      (illegal)
    );

    // ========================================================================
    // test table and bookkeeping
    // ========================================================================
    string      vec_name[$];
    instr_t     vec_instr[$];
    word_t      vec_pc[$];
    alu_op_t    vec_alu_op[$];
    wb_src_t    vec_wb_src[$];
    dmem_type_t vec_dmem[$];
    logic [4:0] vec_flags[$];           // {wb_en, btype, jal, jalr, illegal}
    word_t      vec_imm[$];

    word_t       mirror [32];           // expected register file contents
    logic [31:0] rng_state = 32'ha1125a8f;
    logic        table_ready = 1'b0;
    int          error_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    task automatic add_vec(input string name, input instr_t i, input word_t p,
                           input alu_op_t a, input wb_src_t w, input dmem_type_t d,
                           input logic [4:0] f, input word_t m);
        vec_name.push_back(name);
        vec_instr.push_back(i);
        vec_pc.push_back(p);
        vec_alu_op.push_back(a);
        vec_wb_src.push_back(w);
        vec_dmem.push_back(d);
        vec_flags.push_back(f);
        vec_imm.push_back(m);
    endtask

    `include "tb_id_vectors.svh"

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // r-type, store and branch read rs2 as the second operand
    function automatic logic takes_rs2(input instr_t i);
        return (i[6:0] == OPCODE_RTYPE) || (i[6:0] == OPCODE_STORE) ||
               (i[6:0] == OPCODE_BRANCH);
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %h, actual %h", test, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d mismatches", name, error_count - errors_before);
        end
    endtask

    task automatic check_bundle(input int k);
        string  n;
        instr_t i;
        word_t  exp_op_a;
        word_t  exp_op_b;
        n = vec_name[k];
        i = vec_instr[k];
        exp_op_a = (i[6:0] == OPCODE_AUIPC) ? vec_pc[k] : mirror[i[19:15]];
        exp_op_b = takes_rs2(i) ? mirror[i[24:20]] : vec_imm[k];
        check_value(n, "alu_op", vec_alu_op[k], alu_op);
        check_value(n, "wb_src", vec_wb_src[k], wb_src);
        check_value(n, "dmem_type", vec_dmem[k], dmem_type);
        check_value(n, "wb_en", vec_flags[k][4], wb_en);
        check_value(n, "branch_btype", vec_flags[k][3], btype);
        check_value(n, "branch_jal", vec_flags[k][2], jal);
        check_value(n, "branch_jalr", vec_flags[k][1], jalr);
        check_value(n, "illegal", vec_flags[k][0], illegal);
        check_value(n, "imm", vec_imm[k], imm);
        check_value(n, "op_a", exp_op_a, op_a);
        check_value(n, "op_b", exp_op_b, op_b);
        check_value(n, "rs2_data", mirror[i[24:20]], rs2_data);
        check_value(n, "rd", i[11:7], rd);
    endtask

    task automatic write_register(input int r, input word_t data);
        @(negedge clk);
        instr[19:15] = wb_rd;           // rs1 reads back the previous write
        wb_we   = 1'b1;
        wb_rd   = r[4:0];
        wb_data = data;
        if (r != 0) begin
            mirror[r] = data;           // x0 keeps reading zero
        end
    endtask

    // one four-phase transfer with a random hold before fetch drops req
    task automatic run_row(input int k);
        int    errors_before;
        int    hold;
        string n;
        errors_before = error_count;
        n = vec_name[k];
        @(negedge clk);
        check_value(n, "ack before req", 1'b0, ack);
        req   = 1'b1;
        instr = vec_instr[k];
        pc    = vec_pc[k];
        @(negedge clk);
        check_value(n, "ack one cycle after req", 1'b1, ack);
        check_bundle(k);
        rng_state = xorshift32(rng_state);
        hold = int'(rng_state[1:0]);
        repeat (hold) begin
            rng_state = xorshift32(rng_state);
            instr = rng_state;          // fetch may move on once ack is high
            @(negedge clk);
            check_value(n, "ack while req held", 1'b1, ack);
            check_bundle(k);
        end
        req = 1'b0;
        @(negedge clk);
        check_value(n, "ack one cycle after req drop", 1'b0, ack);
        finish_test(n, errors_before);
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        int errors_before;
        rst_n   = 1'b0;
        req     = 1'b0;
        instr   = INSTR_NOP;
        pc      = '0;
        wb_we   = 1'b0;
        wb_rd   = '0;
        wb_data = '0;
        for (int r = 0; r < 32; r++) begin
            mirror[r] = '0;
        end
        fill_vector_table();
        table_ready = 1'b1;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errors_before = error_count;
        @(negedge clk);
        check_value("reset", "ack", 1'b0, ack);
        check_value("reset", "wb_en", 1'b0, wb_en);
        check_value("reset", "illegal", 1'b0, illegal);
        check_value("reset", "branch_btype", 1'b0, btype);
        check_value("reset", "branch_jal", 1'b0, jal);
        check_value("reset", "branch_jalr", 1'b0, jalr);
        check_value("reset", "dmem_type", DMEM_NONE, dmem_type);
        finish_test("reset", errors_before);

        for (int r = 1; r < 32; r++) begin
            rng_state = xorshift32(rng_state);
            write_register(r, rng_state);
        end
        rng_state = xorshift32(rng_state);
        write_register(0, rng_state | 32'h1);   // nonzero write aimed at x0
        @(negedge clk);
        wb_we = 1'b0;

        for (int k = 0; k < vec_name.size(); k++) begin
            run_row(k);
        end

        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog sized from the table length plus reset and preload
    initial begin
        int limit;
        wait (table_ready);
        limit = vec_name.size() * 20 + 10 + 40 + 10;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the req/ack handshake hung", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- flist.f
+incdir+tests
common/rv_pkg.sv
hw/id_stage/decoder.sv
hw/id_stage/imm_gen.sv
hw/id_stage/reg_file.sv
hw/id_stage/id_stage.sv
tests/tb_id_stage.sv

//--- Bender.yml
package:
  name: rv32im_id_stage

sources:
  # shared package first, then the decode stage blocks
  - files:
      - common/rv_pkg.sv
      - hw/id_stage/decoder.sv
      - hw/id_stage/imm_gen.sv
      - hw/id_stage/reg_file.sv
      - hw/id_stage/id_stage.sv

  # testbench with its vector table header
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_id_stage.sv
